// File: src.f
+incdir+.
a2b_pkg.sv
masked_full_adder.sv
mask_prng.sv
masked_a2b_conv.sv
a2b_top.sv
a2b_checker.sv
tb_a2b_top.sv

// File: Bender.yml
package:
  name: a2b_converter

sources:
  - include_dirs:
      - .
    files:
      - a2b_pkg.sv
      - masked_full_adder.sv
      - mask_prng.sv
      - masked_a2b_conv.sv
      - a2b_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - a2b_checker.sv
      - tb_a2b_top.sv

// File: tb_a2b_top.sv
// Testbench for the masked A2B converter top, random and burst traffic with zeroize
// Expected secrets wait in a queue and are matched in order against each output
`timescale 1ns/100ps
`include "a2b_defs.svh"

module tb_a2b_top;

    localparam int LAT = `A2B_WIDTH + 2;   // Fixed DUT latency in cycles

    logic                 clk;
    logic                 rst_n;
    logic                 zeroize;
    logic                 in_valid;
    a2b_pkg::arith_pair_t in_data;
    logic                 out_valid;
    a2b_pkg::bool_pair_t  out_data;

    a2b_pkg::share_t exp_q[$];   // Secrets still in flight
    logic [31:0]     rng;        // Stimulus generator state
    int              err_cnt;
    int              n_out;      // Outputs seen
    int              n_eq;       // share0 equal to the secret
    int              n_zero;     // share0 all zero
    int              run_len;    // Current out_valid run
    int              best_run;   // Longest run since last clear

    a2b_top u_a2b_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #4 clk = ~clk;   // 8 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] t;
        t = v ^ (v << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // ========================================
    // Output side, read at the falling edge
    // ========================================
    task automatic check_outputs();
        a2b_pkg::share_t got;
        a2b_pkg::share_t exp;
        if (out_valid) begin
            got = out_data.share0 ^ out_data.share1;   // Recombined secret
            n_out++;
            run_len++;
            if (out_data.share0 == '0) n_zero++;
            if (exp_q.size() == 0) begin
                $display("Output at %0t arrived with no operand waiting for it", $time);
                err_cnt++;
            end else begin
                exp = exp_q.pop_front();
                if (out_data.share0 == exp) n_eq++;
                assert (got === exp) else begin
                    $display("ERR t=%0t out_data expected %h actual %h", $time, exp, got);
                    err_cnt++;
                end
            end
        end else begin
            if (run_len > best_run) best_run = run_len;
            run_len = 0;
        end
    endtask

    // One clock of stimulus, outputs first, then new inputs
    task automatic drive_cycle(input logic v, input logic z);
        a2b_pkg::share_t sum;
        @(negedge clk);
        check_outputs();
        rng = xorshift32(rng);
        in_data.share0 = rng[`A2B_WIDTH-1:0];
        rng = xorshift32(rng);
        in_data.share1 = rng[`A2B_WIDTH-1:0];
        sum = in_data.share0 + in_data.share1;   // Wraps at 2^W
        zeroize  = z;
        in_valid = v && !z;
        if (z) begin
            exp_q.delete();   // Wipe drops everything in flight
        end else if (v) begin
            exp_q.push_back(sum);
        end
    endtask

    // Idle until the queue empties, bounded
    task automatic drain();
        int n;
        for (n = 0; n < 2 * LAT && exp_q.size() != 0; n++) begin
            drive_cycle(1'b0, 1'b0);
        end
        if (exp_q.size() != 0) begin
            $display("Timed out waiting for %0d outstanding results", exp_q.size());
            err_cnt++;
        end
        repeat (2) drive_cycle(1'b0, 1'b0);   // Let the last run close
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b1;
        zeroize  = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        rng      = 32'd74;
        err_cnt  = 0;
        n_out    = 0;
        n_eq     = 0;
        n_zero   = 0;
        run_len  = 0;
        best_run = 0;

        @(negedge clk);
        rst_n = 1'b0;            // Real falling edge on reset
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Random traffic, about 75% valid
        for (int i = 0; i < 300; i++) begin
            rng = xorshift32(rng);
            drive_cycle(rng[31:30] != 2'b00, 1'b0);
        end
        drain();

        // Back-to-back burst
        best_run = 0;
        for (int i = 0; i < 24; i++) drive_cycle(1'b1, 1'b0);
        drain();
        if (best_run != 24) begin
            $display("Burst of 24 operands gave a longest output run of %0d", best_run);
            err_cnt++;
        end

        // Wipe with operands in flight, then resume
        for (int i = 0; i < 6; i++) drive_cycle(1'b1, 1'b0);
        repeat (2) drive_cycle(1'b0, 1'b1);
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            drive_cycle(rng[31:30] != 2'b00, 1'b0);
        end
        drain();

        if (n_out == 0 || n_eq == n_out || n_zero == n_out) begin
            $display("Masking not live: %0d outputs, %0d share0 equal secret, %0d share0 zero",
                     n_out, n_eq, n_zero);
            err_cnt++;
        end

        $display("Done: %0d errors, %0d assertion failures, %0d outputs checked",
                 err_cnt, u_a2b_top.u_a2b_checker.fail_cnt, n_out);
        if (err_cnt == 0 && u_a2b_top.u_a2b_checker.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: a2b_checker.sv
// Concurrent checks on the A2B top, bound into every a2b_top instance
// Covers reset, zeroize, fixed latency and share recombination
`timescale 1ns/100ps
`include "a2b_defs.svh"

module a2b_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 zeroize,
    input logic                 in_valid,
    input a2b_pkg::arith_pair_t in_data,
    input logic                 out_valid,
    input a2b_pkg::bool_pair_t  out_data
);

    localparam int LAT = `A2B_WIDTH + 2;

    int unsigned     fail_cnt = 0;   // Read by the testbench at the end
    a2b_pkg::share_t in_sum;         // Arithmetic secret, wraps at 2^W
    a2b_pkg::share_t out_xor;        // Boolean secret

    assign in_sum  = in_data.share0 + in_data.share1;
    assign out_xor = out_data.share0 ^ out_data.share1;

    // ========================================
    // Reset and wipe
    // ========================================
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!out_valid && out_data == '0))
        else begin fail_cnt++; $error("Outputs not cleared during reset"); end

    // Also covers the first edge after release
    a_reset_after: assert property (@(posedge clk) !rst_n |=> (!out_valid && out_data == '0))
        else begin fail_cnt++; $error("Outputs not clear one edge after reset"); end

    a_zeroize: assert property (@(posedge clk) disable iff (!rst_n)
        zeroize |=> (!out_valid && out_data == '0))
        else begin fail_cnt++; $error("Outputs not cleared after zeroize"); end

    // ========================================
    // Latency and result
    // ========================================
    a_latency_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !zeroize) ##1 (!zeroize) [*LAT-1] |=> out_valid)
        else begin fail_cnt++; $error("Accepted operand did not emerge after LAT cycles"); end

    a_latency_back: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, LAT))
        else begin fail_cnt++; $error("out_valid without an operand LAT cycles earlier"); end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_xor == $past(in_sum, LAT)))
        else begin fail_cnt++; $error("Boolean shares do not recombine to the input sum"); end

endmodule

bind a2b_top a2b_checker u_a2b_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .zeroize   (zeroize),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
);

// File: a2b_top.sv
// Masked A2B converter top, mask generator feeding the converter pipeline
// Strobe in, strobe out, fixed latency, no back-pressure
`timescale 1ns/100ps

module a2b_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 zeroize,     // Level, wipes the datapath
    input  logic                 in_valid,    // One-cycle strobe
    input  a2b_pkg::arith_pair_t in_data,
    output logic                 out_valid,
    output a2b_pkg::bool_pair_t  out_data
);

    // Fresh randomness, consumed every cycle
    a2b_pkg::mask_bundle_t masks;

    // ========================================
    // Mask generator
    // ========================================
    mask_prng u_mask_prng (
        .clk   (clk),
        .rst_n (rst_n),
        .masks (masks)
    );

    // ========================================
    // Converter pipeline
    // ========================================
    masked_a2b_conv u_masked_a2b_conv (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .masks     (masks),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: masked_a2b_conv.sv
// Pipelined arithmetic-to-Boolean share converter, latency A2B_WIDTH+2 cycles
// Needs a fresh mask bundle every cycle, accepts one operand per cycle
`timescale 1ns/100ps
`include "a2b_defs.svh"

module masked_a2b_conv (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  zeroize,
    input  logic                  in_valid,
    input  a2b_pkg::arith_pair_t  in_data,
    input  a2b_pkg::mask_bundle_t masks,
    output logic                  out_valid,
    output a2b_pkg::bool_pair_t   out_data
);

    localparam int W   = `A2B_WIDTH;
    localparam int LAT = W + 2;   // Skew + adder + deskew stages

    a2b_pkg::bit_pair_t [W-1:0] carry;     // carry[i] feeds bit i
    a2b_pkg::bit_pair_t [W-1:0] sum_pair;  // Registered sum of bit i
    a2b_pkg::bit_pair_t [W-1:0] res_pair;  // Deskewed result bits
    logic               [LAT-1:0] vld_sr;  // Valid tracking

    assign carry[0] = '0;   // No carry into the LSB

    // ========================================
    // Per-bit skew, add, deskew
    // ========================================
    genvar i;
    generate
        for (i = 0; i < W; i++) begin : gen_bit
            a2b_pkg::bit_pair_t [i:0]     x_dly;   // Bit i reaches adder after i+1 edges
            a2b_pkg::bit_pair_t [i:0]     y_dly;
            a2b_pkg::bit_pair_t [W-1-i:0] s_dly;   // Hold bit i until the MSB catches up

            // Remask into Boolean form, then skew
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    x_dly <= '0;
                    y_dly <= '0;
                end else if (zeroize) begin
                    x_dly <= '0;
                    y_dly <= '0;
                end else begin
                    // {mask, share ^ mask} so XOR of the pair is the share bit
                    x_dly[0] <= {masks.remask0[i], in_data.share0[i] ^ masks.remask0[i]};
                    y_dly[0] <= {masks.remask1[i], in_data.share1[i] ^ masks.remask1[i]};
                    for (int j = 1; j <= i; j++) begin
                        x_dly[j] <= x_dly[j-1];
                        y_dly[j] <= y_dly[j-1];
                    end
                end
            end

            if (i < W-1) begin : gen_fa
                masked_full_adder u_fa (
                    .clk     (clk),
                    .rst_n   (rst_n),
                    .zeroize (zeroize),
                    .x       (x_dly[i]),
                    .y       (y_dly[i]),
                    .c_in    (carry[i]),
                    .rnd     (masks.and_rnd[i]),
                    .s       (sum_pair[i]),
                    .c_out   (carry[i+1])
                );
            end else begin : gen_msb
                // Top bit, carry out is dropped so a plain XOR suffices
                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        sum_pair[i] <= '0;
                    end else if (zeroize) begin
                        sum_pair[i] <= '0;
                    end else begin
                        sum_pair[i] <= x_dly[i] ^ y_dly[i] ^ carry[i];
                    end
                end
            end

            // Deskew line, shorter for higher bits
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    s_dly <= '0;
                end else if (zeroize) begin
                    s_dly <= '0;
                end else begin
                    s_dly[0] <= sum_pair[i];
                    for (int j = 1; j <= W-1-i; j++) begin
                        s_dly[j] <= s_dly[j-1];
                    end
                end
            end

            assign res_pair[i] = s_dly[W-1-i];
        end
    endgenerate

    // ========================================
    // Valid pipeline, same depth as data
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else if (zeroize) begin
            vld_sr <= '0;   // In-flight operands are dropped
        end else begin
            vld_sr <= {vld_sr[LAT-2:0], in_valid};
        end
    end

    assign out_valid = vld_sr[LAT-1];

    // Regroup bit pairs into share vectors
    always_comb begin
        for (int k = 0; k < W; k++) begin
            out_data.share0[k] = res_pair[k][0];
            out_data.share1[k] = res_pair[k][1];
        end
    end

endmodule

// File: mask_prng.sv
// Deterministic mask source, three xorshift32 lanes stepped every cycle
// Bundle is registered; free-running, seeds load only at reset
`timescale 1ns/100ps
`include "a2b_defs.svh"

module mask_prng (
    input  logic                  clk,
    input  logic                  rst_n,
    output a2b_pkg::mask_bundle_t masks
);

    logic [2:0][31:0] state_q;   // Lane states
    logic [2:0][31:0] state_d;   // Next lane states

    // Standard 13/17/5 xorshift step
    function automatic logic [31:0] xs32_step(input logic [31:0] v);
        logic [31:0] t;
        t = v ^ (v << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    always_comb begin
        for (int k = 0; k < 3; k++) begin
            state_d[k] = xs32_step(state_q[k]);
        end
    end

    // ========================================
    // State and bundle registers
    // ========================================
    // No zeroize here, masks must never repeat after a wipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q[0] <= `A2B_SEED0;
            state_q[1] <= `A2B_SEED1;
            state_q[2] <= `A2B_SEED2;
            masks      <= '0;
        end else begin
            state_q         <= state_d;
            masks.and_rnd   <= state_d[0][`A2B_WIDTH-1:0];   // Low bits per lane
            masks.remask0   <= state_d[1][`A2B_WIDTH-1:0];
            masks.remask1   <= state_d[2][`A2B_WIDTH-1:0];
        end
    end

endmodule

// File: masked_full_adder.sv
// First-order masked full adder, one stage of the A2B ripple chain
// Sum and carry shares registered, one cycle latency
`timescale 1ns/100ps

module masked_full_adder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               zeroize,
    input  a2b_pkg::bit_pair_t x,       // Operand x shares
    input  a2b_pkg::bit_pair_t y,       // Operand y shares
    input  a2b_pkg::bit_pair_t c_in,    // Incoming carry shares
    input  logic               rnd,     // Fresh bit for cross terms
    output a2b_pkg::bit_pair_t s,
    output a2b_pkg::bit_pair_t c_out
);

    a2b_pkg::bit_pair_t p;        // Propagate, share-wise x ^ y
    logic               inner0;   // Domain 0 local products
    logic               inner1;   // Domain 1 local products
    logic               cross0;   // Domain 0 cross products, refreshed
    logic               cross1;   // Domain 1 cross products, refreshed
    a2b_pkg::bit_pair_t c_next;

    // Sum is linear, so share-wise XOR is enough
    assign p = x ^ y;

    // ========================================
    // Masked carry = (x & y) ^ (p & c)
    // ========================================
    // DOM style, each AND split into inner and cross domain terms
    assign inner0 = (x[0] & y[0]) ^ (p[0] & c_in[0]);
    assign inner1 = (x[1] & y[1]) ^ (p[1] & c_in[1]);

    // Cross terms never leave a domain without rnd on them
    assign cross0 = (x[0] & y[1]) ^ (p[0] & c_in[1]) ^ rnd;
    assign cross1 = (x[1] & y[0]) ^ (p[1] & c_in[0]) ^ rnd;

    assign c_next[0] = inner0 ^ cross0;
    assign c_next[1] = inner1 ^ cross1;   // rnd cancels in recombination

    // Output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s     <= '0;
            c_out <= '0;
        end else if (zeroize) begin
            s     <= '0;   // Wipe both domains
            c_out <= '0;
        end else begin
            s     <= p ^ c_in;
            c_out <= c_next;
        end
    end

endmodule

// File: a2b_pkg.sv
// Share and mask types common to the converter RTL and its testbench
// Referenced by scoped names only
`include "a2b_defs.svh"

package a2b_pkg;

    // One share of operand or result
    typedef logic [`A2B_WIDTH-1:0] share_t;

    // Two Boolean shares of a single bit, [0] and [1] are the domains
    typedef logic [1:0] bit_pair_t;

    // Arithmetic input, secret = share0 + share1 mod 2^W
    typedef struct packed {
        share_t share1;
        share_t share0;
    } arith_pair_t;

    // Boolean output, secret = share0 ^ share1
    typedef struct packed {
        share_t share1;
        share_t share0;
    } bool_pair_t;

    // Fresh randomness consumed every cycle
    typedef struct packed {
        share_t and_rnd;   // One refresh bit per full adder
        share_t remask0;   // Boolean mask for input share0
        share_t remask1;   // Boolean mask for input share1
    } mask_bundle_t;

endpackage

// File: a2b_defs.svh
// Global sizes and reset seeds for the masked A2B converter
// Include wherever the share width or the mask seeds are needed
`ifndef A2B_DEFS_SVH
`define A2B_DEFS_SVH

// ========================================
// Datapath
// ========================================
`define A2B_WIDTH 8              // Bits per share

// ========================================
// Mask generator reset seeds
// ========================================
// All must be nonzero or the xorshift lane locks up
`define A2B_SEED0 32'h1F3A_5C27  // Lane 0, AND refresh bits
`define A2B_SEED1 32'h9E37_79B9  // Lane 1, remask for share0
`define A2B_SEED2 32'h6A09_E667  // Lane 2, remask for share1

`endif
